/* hw/demosaicPkg.sv */
package demosaicPkg;

	// Frame geometry
	localparam int frameWidth = 16;
	localparam int frameHeight = 8;
	localparam int pixelWidth = 8;
	localparam int pixelCount = frameWidth * frameHeight;

	// Filler strobes push the last rows through the window and pipeline
	localparam int flushStrobes = frameWidth + 5;
	localparam int frameStrobes = pixelCount + flushStrobes;

	localparam int coordWidth = $clog2((frameWidth > frameHeight) ? frameWidth : frameHeight);
	localparam int strobeCntWidth = $clog2(frameStrobes);

	typedef logic [pixelWidth-1:0] pixelT;
	typedef logic [coordWidth-1:0] coordT;
	typedef logic [strobeCntWidth-1:0] strobeCntT;

	localparam coordT lastX = coordT'(frameWidth - 1);
	localparam coordT lastY = coordT'(frameHeight - 1);

	// Strobe indices within a frame period
	localparam strobeCntT centreStart = strobeCntT'(frameWidth + 1);
	localparam strobeCntT centreEnd = strobeCntT'(frameWidth + pixelCount);
	localparam strobeCntT lastStrobe = strobeCntT'(frameStrobes - 1);

	// 3x3 neighbourhood around the centre sample
	typedef struct packed {
		pixelT topLeft;
		pixelT topCentre;
		pixelT topRight;
		pixelT middleLeft;
		pixelT middleCentre;
		pixelT middleRight;
		pixelT bottomLeft;
		pixelT bottomCentre;
		pixelT bottomRight;
	} windowT;

	typedef struct packed {
		coordT x;
		coordT y;
		logic centreValid;
		logic frameEnd;
	} sitePosT;

	typedef enum logic [1:0] {siteGreen, siteBlue, siteRed} bayerSiteT;

	typedef enum logic [1:0] {useVertical, useHorizontal, useBoth} gradChoiceT;

	typedef struct packed {
		pixelT r;
		pixelT g;
		pixelT b;
	} rgbT;

endpackage

/* hw/lineBuffer.sv */
module lineBuffer (
	input logic clk,
	input logic reset,
	input logic inValid,
	input demosaicPkg::pixelT inPixel,
	output demosaicPkg::windowT window
);

	// Previous row and the row before it
	demosaicPkg::pixelT recentRow [demosaicPkg::frameWidth];
	demosaicPkg::pixelT olderRow [demosaicPkg::frameWidth];

	demosaicPkg::coordT col;
	demosaicPkg::pixelT middleTap;
	demosaicPkg::pixelT topTap;

	// Both rows read before write at the shared column address
	assign middleTap = recentRow[col];
	assign topTap = olderRow[col];

	always_ff @(posedge clk) begin
		if (reset) begin
			col <= '0;
		end
		else if (inValid) begin
			if (col == demosaicPkg::lastX) begin
				col <= '0;
			end
			else begin
				col <= col + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			recentRow[col] <= inPixel;
			olderRow[col] <= middleTap;
		end
	end

	// Newest sample enters on the right
	always_ff @(posedge clk) begin
		if (inValid) begin
			window.topRight <= topTap;
			window.topCentre <= window.topRight;
			window.topLeft <= window.topCentre;

			window.middleRight <= middleTap;
			window.middleCentre <= window.middleRight;
			window.middleLeft <= window.middleCentre;

			window.bottomRight <= inPixel;
			window.bottomCentre <= window.bottomRight;
			window.bottomLeft <= window.bottomCentre;
		end
	end

	colInRange: assert property (
		@(posedge clk) disable iff (reset)
		col < demosaicPkg::frameWidth
	);

endmodule

/* hw/frameSequencer.sv */
module frameSequencer (
	input logic clk,
	input logic reset,
	input logic inValid,
	output demosaicPkg::sitePosT sitePos
);

	demosaicPkg::strobeCntT strobeCnt;
	logic inFrame;
	logic firstCentre;
	logic lastCentre;

	// Strobes whose window centre holds a real frame pixel
	assign firstCentre = strobeCnt == demosaicPkg::centreStart;
	assign lastCentre = strobeCnt == demosaicPkg::centreEnd;
	assign inFrame = (strobeCnt >= demosaicPkg::centreStart) &&
		(strobeCnt <= demosaicPkg::centreEnd);

	always_ff @(posedge clk) begin
		if (reset) begin
			strobeCnt <= '0;
		end
		else if (inValid) begin
			if (strobeCnt == demosaicPkg::lastStrobe) begin
				strobeCnt <= '0;
			end
			else begin
				strobeCnt <= strobeCnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			sitePos <= '0;
		end
		else if (inValid) begin
			sitePos.centreValid <= inFrame;
			sitePos.frameEnd <= lastCentre;

			if (firstCentre) begin
				sitePos.x <= '0;
				sitePos.y <= '0;
			end
			else if (inFrame) begin
				// Raster step for the pixel now at the centre
				if (sitePos.x == demosaicPkg::lastX) begin
					sitePos.x <= '0;
					sitePos.y <= sitePos.y + 1'b1;
				end
				else begin
					sitePos.x <= sitePos.x + 1'b1;
				end
			end
		end
	end

	frameEndInFrame: assert property (
		@(posedge clk) disable iff (reset)
		sitePos.frameEnd |-> sitePos.centreValid &&
			sitePos.x == demosaicPkg::lastX && sitePos.y == demosaicPkg::lastY
	);

endmodule

/* hw/greenInterp.sv */
module greenInterp (
	input logic clk,
	input logic reset,
	input logic inValid,
	input demosaicPkg::windowT window,
	input demosaicPkg::sitePosT sitePos,
	output demosaicPkg::sitePosT sitePosOut,
	output demosaicPkg::pixelT centre,
	output demosaicPkg::pixelT green
);

	// Stage 1 border flags and sums
	logic atLeft;
	logic atRight;
	logic atTop;
	logic atBottom;
	logic [demosaicPkg::pixelWidth:0] sumH;
	logic [demosaicPkg::pixelWidth:0] sumV;
	logic [demosaicPkg::pixelWidth:0] sumBoth;

	// Masked neighbours and direction averages
	demosaicPkg::pixelT leftQ;
	demosaicPkg::pixelT rightQ;
	demosaicPkg::pixelT upQ;
	demosaicPkg::pixelT downQ;
	demosaicPkg::pixelT avgH1;
	demosaicPkg::pixelT avgV1;

	// Stage 2
	demosaicPkg::pixelT gradH;
	demosaicPkg::pixelT gradV;
	demosaicPkg::pixelT avgH2;
	demosaicPkg::pixelT avgV2;
	demosaicPkg::pixelT avgBoth2;

	demosaicPkg::gradChoiceT choice;

	demosaicPkg::sitePosT posPipe [3];
	demosaicPkg::pixelT centrePipe [3];

	function automatic demosaicPkg::pixelT absDiff(
		input demosaicPkg::pixelT a,
		input demosaicPkg::pixelT b
	);
		return (a > b) ? a - b : b - a;
	endfunction

	assign atLeft = sitePos.x == '0;
	assign atRight = sitePos.x == demosaicPkg::lastX;
	assign atTop = sitePos.y == '0;
	assign atBottom = sitePos.y == demosaicPkg::lastY;

	assign sumH = {1'b0, window.middleLeft} + {1'b0, window.middleRight};
	assign sumV = {1'b0, window.topCentre} + {1'b0, window.bottomCentre};
	assign sumBoth = {1'b0, avgH1} + {1'b0, avgV1};

	always_ff @(posedge clk) begin
		if (inValid) begin
			// Missing neighbours count as zero in the gradients
			leftQ <= atLeft ? '0 : window.middleLeft;
			rightQ <= atRight ? '0 : window.middleRight;
			upQ <= atTop ? '0 : window.topCentre;
			downQ <= atBottom ? '0 : window.bottomCentre;

			// At a border the average is the one neighbour present
			if (atLeft) begin
				avgH1 <= window.middleRight;
			end
			else if (atRight) begin
				avgH1 <= window.middleLeft;
			end
			else begin
				avgH1 <= sumH[demosaicPkg::pixelWidth:1];
			end

			if (atTop) begin
				avgV1 <= window.bottomCentre;
			end
			else if (atBottom) begin
				avgV1 <= window.topCentre;
			end
			else begin
				avgV1 <= sumV[demosaicPkg::pixelWidth:1];
			end
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			gradH <= absDiff(leftQ, rightQ);
			gradV <= absDiff(upQ, downQ);
			avgH2 <= avgH1;
			avgV2 <= avgV1;
			avgBoth2 <= sumBoth[demosaicPkg::pixelWidth:1];
		end
	end

	// Interpolate along the smoother direction
	always_comb begin
		if (gradH > gradV) begin
			choice = demosaicPkg::useVertical;
		end
		else if (gradH < gradV) begin
			choice = demosaicPkg::useHorizontal;
		end
		else begin
			choice = demosaicPkg::useBoth;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			case (choice)
				demosaicPkg::useVertical: green <= avgV2;
				demosaicPkg::useHorizontal: green <= avgH2;
				default: green <= avgBoth2;
			endcase
		end
	end

	// Site info and centre sample follow the three stages
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 3; i++) begin
				posPipe[i] <= '0;
			end
		end
		else if (inValid) begin
			posPipe[0] <= sitePos;
			posPipe[1] <= posPipe[0];
			posPipe[2] <= posPipe[1];
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			centrePipe[0] <= window.middleCentre;
			centrePipe[1] <= centrePipe[0];
			centrePipe[2] <= centrePipe[1];
		end
	end

	assign sitePosOut = posPipe[2];
	assign centre = centrePipe[2];

endmodule

/* hw/pixelAssembler.sv */
module pixelAssembler (
	input logic clk,
	input logic reset,
	input logic inValid,
	input demosaicPkg::sitePosT sitePos,
	input demosaicPkg::pixelT centre,
	input demosaicPkg::pixelT green,
	output demosaicPkg::rgbT outRgb,
	output logic outValid,
	output logic frameDone
);

	demosaicPkg::bayerSiteT site;

	// G on matching parities, B on even rows, R on odd rows
	always_comb begin
		if (sitePos.x[0] == sitePos.y[0]) begin
			site = demosaicPkg::siteGreen;
		end
		else if (!sitePos.y[0]) begin
			site = demosaicPkg::siteBlue;
		end
		else begin
			site = demosaicPkg::siteRed;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid) begin
			case (site)
				demosaicPkg::siteBlue: begin
					outRgb.r <= '0;
					outRgb.g <= green;
					outRgb.b <= centre;
				end
				demosaicPkg::siteRed: begin
					outRgb.r <= centre;
					outRgb.g <= green;
					outRgb.b <= '0;
				end
				default: begin
					outRgb.r <= '0;
					outRgb.g <= centre;
					outRgb.b <= '0;
				end
			endcase
		end
	end

	// Single-cycle pulses after each accepted strobe
	always_ff @(posedge clk) begin
		if (reset) begin
			outValid <= 1'b0;
			frameDone <= 1'b0;
		end
		else begin
			outValid <= inValid && sitePos.centreValid;
			frameDone <= inValid && sitePos.frameEnd;
		end
	end

	noHeldValid: assert property (
		@(posedge clk) disable iff (reset)
		outValid && !inValid |=> !outValid
	);

endmodule

/* hw/bayerDemosaic.sv */
module bayerDemosaic (
	input logic clk,
	input logic reset,
	input logic inValid,
	input demosaicPkg::pixelT inPixel,
	output demosaicPkg::rgbT outRgb,
	output logic outValid,
	output logic frameDone
);

	demosaicPkg::windowT window;
	demosaicPkg::sitePosT sitePos;
	demosaicPkg::sitePosT greenPos;
	demosaicPkg::pixelT centre;
	demosaicPkg::pixelT green;

	lineBuffer lineBuffer_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inPixel(inPixel),
		.window(window)
	);

	frameSequencer frameSequencer_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.sitePos(sitePos)
	);

	greenInterp greenInterp_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.window(window),
		.sitePos(sitePos),
		.sitePosOut(greenPos),
		.centre(centre),
		.green(green)
	);

	pixelAssembler pixelAssembler_i (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.sitePos(greenPos),
		.centre(centre),
		.green(green),
		.outRgb(outRgb),
		.outValid(outValid),
		.frameDone(frameDone)
	);

endmodule

/* dv/demosaicModel.svh */
// Input frames by frame number and raster index
demosaicPkg::pixelT frameStore [3][demosaicPkg::pixelCount];

// Outside the frame a sample counts as zero
function automatic int sampleAt(input int f, input int x, input int y);
	if (x < 0 || y < 0 ||
		x >= demosaicPkg::frameWidth || y >= demosaicPkg::frameHeight) begin
		return 0;
	end
	return int'(frameStore[f][y * demosaicPkg::frameWidth + x]);
endfunction

// Green at a red or blue site from its four green neighbours
function automatic int modelGreen(input int f, input int x, input int y);
	int left;
	int right;
	int up;
	int down;
	int avgH;
	int avgV;
	int gradH;
	int gradV;
	left = sampleAt(f, x - 1, y);
	right = sampleAt(f, x + 1, y);
	up = sampleAt(f, x, y - 1);
	down = sampleAt(f, x, y + 1);
	// A border average is just the neighbour that exists
	avgH = (x == 0) ? right : (x == demosaicPkg::frameWidth - 1) ? left : (left + right) / 2;
	avgV = (y == 0) ? down : (y == demosaicPkg::frameHeight - 1) ? up : (up + down) / 2;
	gradH = (left > right) ? left - right : right - left;
	gradV = (up > down) ? up - down : down - up;
	if (gradH == gradV) begin
		return (avgH + avgV) / 2;
	end
	// Smaller gradient wins
	return (gradH > gradV) ? avgV : avgH;
endfunction

// Expected output for raster index k of frame f
function automatic demosaicPkg::rgbT modelRgb(input int f, input int k);
	int x;
	int y;
	demosaicPkg::pixelT own;
	demosaicPkg::rgbT rgb;
	x = k % demosaicPkg::frameWidth;
	y = k / demosaicPkg::frameWidth;
	own = demosaicPkg::pixelT'(sampleAt(f, x, y));
	rgb = '0;
	if (x % 2 == y % 2) begin
		rgb.g = own;
	end
	else begin
		rgb.g = demosaicPkg::pixelT'(modelGreen(f, x, y));
		// Even rows carry blue, odd rows red
		if (y % 2 == 0) begin
			rgb.b = own;
		end
		else begin
			rgb.r = own;
		end
	end
	return rgb;
endfunction

/* dv/bayerDemosaicTb.sv */
module bayerDemosaicTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int frameCount = 3;
	localparam int lastIndex = demosaicPkg::pixelCount - 1;
	localparam int cycleLimit = frameCount * demosaicPkg::frameStrobes * 4 + 200;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic inValid = 1'b0;
	demosaicPkg::pixelT inPixel = '0;
	demosaicPkg::rgbT outRgb;
	logic outValid;
	logic frameDone;

	logic [31:0] rngState = 32'd87;
	int strobeCount;
	int outIndex;
	int outFrame;
	int cycleCount = 0;
	int reportNext = -1;
	int passCount = 0;
	int failCount = 0;
	int errorCount = 0;
	int testErrors [4] = '{default: 0};
	string testNames [4] = '{"reset quiet", "crafted gradients", "random pixels", "random gaps"};
	demosaicPkg::rgbT expectedRgb;
	demosaicPkg::rgbT gapFreeRgb [demosaicPkg::pixelCount];

	`include "demosaicModel.svh"

	bayerDemosaic bayerDemosaic_i (.*);

	always #2 clk = ~clk;

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		return v ^ (v << 5);
	endfunction

	// Horizontal ramp rows, vertical ramp rows, then a diagonal ramp with equal gradients
	function automatic demosaicPkg::pixelT craftedPixel(input int k);
		int x;
		int y;
		x = k % demosaicPkg::frameWidth;
		y = k / demosaicPkg::frameWidth;
		return demosaicPkg::pixelT'(y < 3 ? x * 15 : y < 5 ? y * 30 : (x + y) * 10);
	endfunction

	function automatic int testOfFrame(input int frame);
		return (frame < frameCount) ? frame + 1 : frameCount;
	endfunction

	task automatic pushStrobe(input demosaicPkg::pixelT pixel, input int idle);
		repeat (idle) begin
			@(posedge clk);
			inValid <= 1'b0;
		end
		@(posedge clk);
		inValid <= 1'b1;
		inPixel <= pixel;
	endtask

	task automatic streamFrame(input int f, input bit withGaps);
		int idle;
		for (int i = 0; i < demosaicPkg::frameStrobes; i++) begin
			idle = 0;
			if (withGaps) begin
				rngState = xorshift(rngState);
				idle = rngState % 3;
			end
			// Filler strobes carry don't-care data
			pushStrobe((i < demosaicPkg::pixelCount) ? frameStore[f][i] : 8'hA5, idle);
		end
	endtask

	task automatic valueMismatch(input int test, input demosaicPkg::rgbT expected,
		input demosaicPkg::rgbT actual);
		testErrors[test]++;
		errorCount++;
		$display("CHECK FAILED %s: expected %h actual %h", testNames[test], expected, actual);
	endtask

	task automatic protocolFault(input int test, input string what);
		testErrors[test]++;
		errorCount++;
		$display("Error in %s: %s", testNames[test], what);
	endtask

	// Raster index of the next output pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			strobeCount <= 0;
			outIndex <= 0;
			outFrame <= 0;
		end
		else begin
			strobeCount <= strobeCount + int'(inValid);
			if (outValid) begin
				outIndex <= (outIndex == lastIndex) ? 0 : outIndex + 1;
				outFrame <= outFrame + int'(outIndex == lastIndex);
			end
			if (outValid && outFrame == 1) begin
				gapFreeRgb[outIndex] <= outRgb;
			end
		end
	end

	assign expectedRgb = modelRgb((outFrame < frameCount) ? outFrame : 0, outIndex);

	quietAfterReset: assert property (@(posedge clk) disable iff (reset)
		(outValid || frameDone) |-> strobeCount > demosaicPkg::frameWidth + 5)
		else protocolFault(0, "output pulse before the pipeline filled");

	followsStrobe: assert property (@(posedge clk) disable iff (reset)
		(outValid || frameDone) |-> $past(inValid) && outFrame < frameCount)
		else protocolFault(testOfFrame($sampled(outFrame)), "output pulse without a strobe");

	rgbMatch: assert property (@(posedge clk) disable iff (reset)
		outValid && outFrame < frameCount |-> outRgb == expectedRgb)
		else valueMismatch(testOfFrame($sampled(outFrame)), $sampled(expectedRgb),
			$sampled(outRgb));

	// Gapped frame repeats the gap-free one
	gapMatch: assert property (@(posedge clk) disable iff (reset)
		outValid && outFrame == 2 |-> outRgb == gapFreeRgb[outIndex])
		else valueMismatch(3, $sampled(gapFreeRgb[outIndex]), $sampled(outRgb));

	lastPixelDone: assert property (@(posedge clk) disable iff (reset)
		(outValid || frameDone) |-> frameDone == (outValid && outIndex == lastIndex))
		else protocolFault(testOfFrame($sampled(outFrame)), "frameDone not on the last pixel");

	// One cycle late so the last checks of a test have run
	always @(posedge clk) begin
		if (reportNext >= 0 && testErrors[reportNext] == 0) begin
			passCount++;
			$display("%s: passed", testNames[reportNext]);
		end
		else if (reportNext >= 0) begin
			failCount++;
			$display("%s: failed with %0d errors", testNames[reportNext], testErrors[reportNext]);
		end
		if (outValid && outFrame == 0 && outIndex == 0) begin
			reportNext <= 0;
		end
		else if (outValid && outIndex == lastIndex && outFrame < frameCount) begin
			reportNext <= outFrame + 1;
		end
		else begin
			reportNext <= -1;
		end
	end

	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("Timeout: outputs still missing after %0d cycles", cycleLimit);
			$display("TEST FAIL");
			$finish;
		end
	end

	initial begin
		for (int k = 0; k < demosaicPkg::pixelCount; k++) begin
			frameStore[0][k] = craftedPixel(k);
			rngState = xorshift(rngState);
			frameStore[1][k] = rngState[7:0];
			frameStore[2][k] = rngState[7:0];
		end
		repeat (10) @(posedge clk);
		reset <= 1'b0;
		// Three frames back to back with gaps only in the last
		for (int f = 0; f < frameCount; f++) begin
			streamFrame(f, f == frameCount - 1);
		end
		@(posedge clk);
		inValid <= 1'b0;
		while (outFrame < frameCount) begin
			@(posedge clk);
		end
		repeat (3) @(posedge clk);
		$display("tests passed: %0d, failed: %0d", passCount, failCount);
		if (passCount == 4 && errorCount == 0) begin
			$display("TEST PASS");
		end
		else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* bayerDemosaic.f */
+incdir+dv
hw/demosaicPkg.sv
hw/lineBuffer.sv
hw/frameSequencer.sv
hw/greenInterp.sv
hw/pixelAssembler.sv
hw/bayerDemosaic.sv
dv/bayerDemosaicTb.sv

/* run.sh */
#!/bin/sh
# Build and run the demosaic testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
	-f bayerDemosaic.f --top-module bayerDemosaicTb \
	-Mdir build/obj

./build/obj/VbayerDemosaicTb | tee build/sim.log

if grep -q "TEST FAIL" build/sim.log; then
	exit 1
fi
